// File: include/dsp_params.svh
`ifndef DSP_PARAMS_SVH
`define DSP_PARAMS_SVH

// Lanes per code vector
`define CHANNEL_WIDTH 4

// Signed ADC code width
`define CODE_PRECISION 8

// Signed FFE tap weight width
`define WEIGHT_PRECISION 8

// Per-lane right shift amount
`define SHIFT_PRECISION 4

// Signed estimate width after saturation
`define OUTPUT_PRECISION 10

// Taps per lane
`define FFE_LENGTH 3

`define TAG_WIDTH 8

// Registers between the FFE and est_out
`define EST_PIPELINE_DEPTH 2

`endif

// File: verilog/constant_pkg.sv
`include "dsp_params.svh"

package constant_pkg;

    // Delay tag carried next to every vector
    typedef logic [`TAG_WIDTH-1:0] tag_t;

    typedef logic signed [`CODE_PRECISION-1:0] code_t;

    // One code per lane, lane 0 first in stream order
    typedef code_t [`CHANNEL_WIDTH-1:0] code_vec_t;

    typedef struct packed {
        tag_t      tag;
        code_vec_t codes;
    } code_word_t;

endpackage

// File: verilog/ffe_pkg.sv
`include "dsp_params.svh"

package ffe_pkg;

    typedef logic signed [`WEIGHT_PRECISION-1:0] weight_t;

    // Indexed [tap][lane]
    typedef weight_t [`FFE_LENGTH-1:0][`CHANNEL_WIDTH-1:0] weight_arr_t;

    typedef logic [`CHANNEL_WIDTH-1:0][`SHIFT_PRECISION-1:0] shift_arr_t;

    // Set bit drops that tap product for that lane
    typedef logic [`FFE_LENGTH-1:0][`CHANNEL_WIDTH-1:0] disable_arr_t;

    typedef logic signed [`OUTPUT_PRECISION-1:0] est_t;

    typedef est_t [`CHANNEL_WIDTH-1:0] est_vec_t;

    typedef struct packed {
        constant_pkg::tag_t tag;
        est_vec_t           est;
    } est_word_t;

    // PAM4 levels from most negative to most positive
    typedef enum logic [1:0] {
        SYM_N3 = 2'd0,
        SYM_N1 = 2'd1,
        SYM_P1 = 2'd2,
        SYM_P3 = 2'd3
    } sym_t;

    typedef sym_t [`CHANNEL_WIDTH-1:0] sym_vec_t;

    typedef struct packed {
        constant_pkg::tag_t tag;
        sym_vec_t           syms;
    } sym_word_t;

endpackage

// File: verilog/code_history_buffer.sv
`include "dsp_params.svh"

module code_history_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  constant_pkg::code_word_t code_in,
    output constant_pkg::code_word_t cur_word,
    output constant_pkg::code_vec_t  prev_codes
);
    import constant_pkg::*;

    code_word_t cur_q;
    code_vec_t  prev_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cur_q  <= '0;
            prev_q <= '0;
        end else begin
            cur_q  <= code_in;
            // Older vector only needs its codes for the FFE window
            prev_q <= cur_q.codes;
        end
    end

    assign cur_word   = cur_q;
    assign prev_codes = prev_q;

endmodule

// File: verilog/comb_ffe.sv
`include "dsp_params.svh"

module comb_ffe (
    input  constant_pkg::code_word_t cur_word,
    input  constant_pkg::code_vec_t  prev_codes,
    input  ffe_pkg::weight_arr_t     weights,
    input  ffe_pkg::shift_arr_t      ffe_shift,
    input  ffe_pkg::disable_arr_t    disable_product,
    output ffe_pkg::est_word_t       ffe_word
);
    import constant_pkg::*;
    import ffe_pkg::*;

    localparam int PROD_W  = `CODE_PRECISION + `WEIGHT_PRECISION;
    localparam int SUM_W   = PROD_W + $clog2(`FFE_LENGTH);
    localparam int EST_MAX = (1 << (`OUTPUT_PRECISION - 1)) - 1;
    localparam int EST_MIN = -(1 << (`OUTPUT_PRECISION - 1));

    // Serial window, oldest code at position 0
    code_t [2*`CHANNEL_WIDTH-1:0] window;
    est_vec_t                     est;

    assign window = {cur_word.codes, prev_codes};

    always_comb begin
        logic signed [PROD_W-1:0] prod;
        logic signed [SUM_W-1:0]  acc;
        logic signed [SUM_W-1:0]  shifted;

        prod    = '0;
        acc     = '0;
        shifted = '0;
        est     = '0;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            acc = '0;
            for (int k = 0; k < `FFE_LENGTH; k++) begin
                // Tap k reaches k codes back, possibly into the previous vector
                prod = $signed(weights[k][i]) * $signed(window[`CHANNEL_WIDTH + i - k]);
                if (disable_product[k][i]) begin
                    prod = '0;
                end
                acc = acc + prod;
            end

            shifted = acc >>> ffe_shift[i];

            // Clamp to the estimate range
            if (shifted > EST_MAX) begin
                est[i] = est_t'(EST_MAX);
            end else if (shifted < EST_MIN) begin
                est[i] = est_t'(EST_MIN);
            end else begin
                est[i] = est_t'(shifted);
            end
        end
    end

    assign ffe_word = '{tag: cur_word.tag, est: est};

endmodule

// File: verilog/est_bits_pipeline.sv
`include "dsp_params.svh"

module est_bits_pipeline #(
    parameter int depth = `EST_PIPELINE_DEPTH
) (
    input  logic               clk,
    input  logic               rst_n,
    input  ffe_pkg::est_word_t ffe_word,
    output ffe_pkg::est_word_t slice_word,
    output ffe_pkg::est_word_t est_out
);
    import ffe_pkg::*;

    est_word_t stage_q [depth];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < depth; j++) begin
                stage_q[j] <= '0;
            end
        end else begin
            stage_q[0] <= ffe_word;
            for (int j = 1; j < depth; j++) begin
                stage_q[j] <= stage_q[j-1];
            end
        end
    end

    // First stage feeds the slicer so its symbols trail est_out by one cycle
    assign slice_word = stage_q[0];
    assign est_out    = stage_q[depth-1];

endmodule

// File: verilog/pam4_slicer.sv
`include "dsp_params.svh"

module pam4_slicer (
    input  logic                                clk,
    input  logic                                rst_n,
    input  ffe_pkg::est_word_t                  slice_word,
    input  logic signed [`OUTPUT_PRECISION-1:0] bit_level,
    input  logic [1:0]                          align_pos,
    output ffe_pkg::sym_word_t                  sym_out
);
    import ffe_pkg::*;

    // One extra bit so negating the most negative level cannot wrap
    logic signed [`OUTPUT_PRECISION:0] neg_level;

    sym_vec_t                    slice_syms;
    sym_word_t                   new_q;
    sym_word_t                   old_q;
    sym_t [2*`CHANNEL_WIDTH-1:0] joined;
    sym_vec_t                    aligned;

    assign neg_level = -$signed({bit_level[`OUTPUT_PRECISION-1], bit_level});

    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            if ($signed(slice_word.est[i]) >= bit_level) begin
                slice_syms[i] = SYM_P3;
            end else if ($signed(slice_word.est[i]) >= 0) begin
                slice_syms[i] = SYM_P1;
            end else if ($signed(slice_word.est[i]) >= neg_level) begin
                slice_syms[i] = SYM_N1;
            end else begin
                slice_syms[i] = SYM_N3;
            end
        end
    end

    // Zero reset leaves every lane at SYM_N3
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            new_q <= '0;
            old_q <= '0;
        end else begin
            new_q <= '{tag: slice_word.tag, syms: slice_syms};
            old_q <= new_q;
        end
    end

    // Older vector occupies positions 0 to 3
    assign joined = {new_q.syms, old_q.syms};

    always_comb begin
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            aligned[i] = joined[i + align_pos];
        end
    end

    assign sym_out = '{tag: old_q.tag, syms: aligned};

endmodule

// File: verilog/bits_estimator_datapath.sv
`include "dsp_params.svh"

module bits_estimator_datapath (
    input  logic                                clk,
    input  logic                                rst_n,
    input  constant_pkg::code_word_t            code_in,
    input  ffe_pkg::weight_arr_t                weights,
    input  ffe_pkg::shift_arr_t                 ffe_shift,
    input  ffe_pkg::disable_arr_t               disable_product,
    input  logic signed [`OUTPUT_PRECISION-1:0] bit_level,
    input  logic [1:0]                          align_pos,
    output constant_pkg::code_word_t            code_out,
    output ffe_pkg::est_word_t                  est_out,
    output ffe_pkg::sym_word_t                  sym_out
);
    import constant_pkg::*;
    import ffe_pkg::*;

    code_word_t cur_word;
    code_vec_t  prev_codes;
    est_word_t  ffe_word;
    est_word_t  slice_word;
    code_word_t code_dly_q [`EST_PIPELINE_DEPTH];

    code_history_buffer u_code_history_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .code_in    (code_in),
        .cur_word   (cur_word),
        .prev_codes (prev_codes)
    );

    comb_ffe u_comb_ffe (
        .cur_word        (cur_word),
        .prev_codes      (prev_codes),
        .weights         (weights),
        .ffe_shift       (ffe_shift),
        .disable_product (disable_product),
        .ffe_word        (ffe_word)
    );

    est_bits_pipeline #(
        .depth (`EST_PIPELINE_DEPTH)
    ) u_est_bits_pipeline (
        .clk        (clk),
        .rst_n      (rst_n),
        .ffe_word   (ffe_word),
        .slice_word (slice_word),
        .est_out    (est_out)
    );

    pam4_slicer u_pam4_slicer (
        .clk        (clk),
        .rst_n      (rst_n),
        .slice_word (slice_word),
        .bit_level  (bit_level),
        .align_pos  (align_pos),
        .sym_out    (sym_out)
    );

    // Raw codes delayed to line up with est_out
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < `EST_PIPELINE_DEPTH; j++) begin
                code_dly_q[j] <= '0;
            end
        end else begin
            code_dly_q[0] <= cur_word;
            for (int j = 1; j < `EST_PIPELINE_DEPTH; j++) begin
                code_dly_q[j] <= code_dly_q[j-1];
            end
        end
    end

    assign code_out = code_dly_q[`EST_PIPELINE_DEPTH-1];

endmodule

// File: sim/bits_estimator_assert.sv
module bits_estimator_assert (
    input logic                     clk,
    input logic                     rst_n,
    input constant_pkg::code_word_t code_in,
    input constant_pkg::code_word_t code_out,
    input ffe_pkg::est_word_t       est_out,
    input ffe_pkg::sym_word_t       sym_out
);
    timeunit 1ns;
    timeprecision 1ps;

    // Saturating count of clean cycles since reset
    logic [2:0] run_cnt;

    // Number of failed assertions
    int fail_count = 0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_cnt <= '0;
        end else if (run_cnt != 3'd7) begin
            run_cnt <= run_cnt + 3'd1;
        end
    end

    a_est_code_tag: assert property (@(posedge clk) disable iff (!rst_n)
        run_cnt >= 3'd3 |-> est_out.tag == $past(code_in.tag, 3)
                            && code_out.tag == $past(code_in.tag, 3))
        else begin
            fail_count++;
            $error("est_out or code_out tag does not trail code_in by 3 cycles");
        end

    a_sym_tag: assert property (@(posedge clk) disable iff (!rst_n)
        run_cnt >= 3'd4 |-> sym_out.tag == $past(code_in.tag, 4))
        else begin
            fail_count++;
            $error("sym_out tag does not trail code_in by 4 cycles");
        end

    a_reset_zero: assert property (@(posedge clk)
        !rst_n |=> code_out == '0 && est_out == '0 && sym_out == '0)
        else begin
            fail_count++;
            $error("outputs not cleared one cycle after reset");
        end

endmodule

bind bits_estimator_datapath bits_estimator_assert u_bits_estimator_assert (
    .clk      (clk),
    .rst_n    (rst_n),
    .code_in  (code_in),
    .code_out (code_out),
    .est_out  (est_out),
    .sym_out  (sym_out)
);

// File: sim/tb_bits_estimator.sv
`include "dsp_params.svh"

module tb_bits_estimator;
    timeunit 1ns;
    timeprecision 1ps;

    import constant_pkg::*;
    import ffe_pkg::*;

    localparam int EST_MAX    = (1 << (`OUTPUT_PRECISION - 1)) - 1;
    localparam int EST_MIN    = -(1 << (`OUTPUT_PRECISION - 1));
    localparam int WAIT_LIMIT = 10;

    logic                                clk;
    logic                                rst_n;
    code_word_t                          code_in;
    weight_arr_t                         weights;
    shift_arr_t                          ffe_shift;
    disable_arr_t                        disable_product;
    logic signed [`OUTPUT_PRECISION-1:0] bit_level;
    logic [1:0]                          align_pos;
    code_word_t                          code_out;
    est_word_t                           est_out;
    sym_word_t                           sym_out;

    logic [15:0] lfsr_state;
    code_word_t  code_q [$];
    est_word_t   est_q [$];
    sym_word_t   sym_q [$];
    code_vec_t   model_prev;
    int          skip_checks;
    int          check_count;
    int          error_count;
    int          test_start_errors;

    bits_estimator_datapath u_bits_estimator_datapath (
        .clk             (clk),
        .rst_n           (rst_n),
        .code_in         (code_in),
        .weights         (weights),
        .ffe_shift       (ffe_shift),
        .disable_product (disable_product),
        .bit_level       (bit_level),
        .align_pos       (align_pos),
        .code_out        (code_out),
        .est_out         (est_out),
        .sym_out         (sym_out)
    );

    always #10 clk = ~clk;

    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int b = 0; b < n; b++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return r;
    endfunction

    // Tags stay below 8'h80 so 8'hFF can serve as a marker
    function automatic code_word_t random_word();
        code_word_t w;
        w.tag = tag_t'(rand_bits(7));
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            w.codes[i] = code_t'(rand_bits(8));
        end
        return w;
    endfunction

    // Large codes of one sign with magnitude 64 and up
    function automatic code_word_t strong_word(input bit positive);
        code_word_t w;
        w.tag = tag_t'(rand_bits(7));
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            if (positive) w.codes[i] = code_t'(64 + int'(rand_bits(6)));
            else w.codes[i] = code_t'(int'(rand_bits(6)) - 128);
        end
        return w;
    endfunction

    function automatic weight_arr_t random_weights();
        weight_arr_t w;
        for (int k = 0; k < `FFE_LENGTH; k++) begin
            for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
                w[k][i] = weight_t'(rand_bits(8));
            end
        end
        return w;
    endfunction

    function automatic shift_arr_t same_shift(input int amount);
        shift_arr_t s;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            s[i] = amount[`SHIFT_PRECISION-1:0];
        end
        return s;
    endfunction

    // Serial window holds older codes at 0..3 and newer codes at 4..7
    function automatic est_vec_t model_ffe(input code_vec_t cur, input code_vec_t prev);
        int       window [2*`CHANNEL_WIDTH];
        int       sum;
        est_vec_t result;
        for (int p = 0; p < `CHANNEL_WIDTH; p++) begin
            window[p] = int'(prev[p]);
            window[p + `CHANNEL_WIDTH] = int'(cur[p]);
        end
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            sum = 0;
            for (int k = 0; k < `FFE_LENGTH; k++) begin
                if (!disable_product[k][i])
                    sum += int'(weights[k][i]) * window[`CHANNEL_WIDTH + i - k];
            end
            sum = sum >>> ffe_shift[i];
            if (sum > EST_MAX) sum = EST_MAX;
            else if (sum < EST_MIN) sum = EST_MIN;
            result[i] = est_t'(sum);
        end
        return result;
    endfunction

    function automatic sym_vec_t model_slice(input est_vec_t e);
        sym_vec_t s;
        int       v;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            v = int'(e[i]);
            if (v >= int'(bit_level)) s[i] = SYM_P3;
            else if (v >= 0) s[i] = SYM_P1;
            else if (v >= -int'(bit_level)) s[i] = SYM_N1;
            else s[i] = SYM_N3;
        end
        return s;
    endfunction

    function automatic sym_word_t expected_sym_out(input sym_word_t older, input sym_word_t newer,
                                                   input logic [1:0] pos);
        sym_word_t r;
        int        p;
        r.tag = older.tag;
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            p = i + int'(pos);
            if (p < `CHANNEL_WIDTH) r.syms[i] = older.syms[p];
            else r.syms[i] = newer.syms[p - `CHANNEL_WIDTH];
        end
        return r;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] expected,
                               input string what);
        check_count++;
        if (got !== expected) begin
            error_count++;
            $display("** Error at time %0t: %s is %h, expected %h", $time, what, got, expected);
        end
    endtask

    task automatic drive_word(input code_word_t w);
        est_word_t e;
        sym_word_t s;
        code_in = w;
        e.tag   = w.tag;
        e.est   = model_ffe(w.codes, model_prev);
        s.tag   = w.tag;
        s.syms  = model_slice(e.est);
        code_q.push_back(w);
        est_q.push_back(e);
        sym_q.push_back(s);
        model_prev = w.codes;
    endtask

    // Check outputs just after the edge and then drive the next word
    task automatic step(input code_word_t w);
        code_word_t exp_code;
        est_word_t  exp_est;
        sym_word_t  exp_sym;
        @(posedge clk);
        #1;
        exp_code = code_q.pop_front();
        exp_est  = est_q.pop_front();
        exp_sym  = expected_sym_out(sym_q[0], sym_q[1], align_pos);
        sym_q.delete(0);
        if (skip_checks > 0) begin
            skip_checks--;
        end else begin
            check_value(code_out, exp_code, "code_out");
            check_value(est_out, exp_est, "est_out");
            check_value(sym_out, exp_sym, "sym_out");
        end
        #1;
        drive_word(w);
    endtask

    task automatic apply_settings(input weight_arr_t w, input shift_arr_t s,
                                  input disable_arr_t d,
                                  input logic signed [`OUTPUT_PRECISION-1:0] level,
                                  input logic [1:0] pos);
        weights         = w;
        ffe_shift       = s;
        disable_product = d;
        bit_level       = level;
        align_pos       = pos;
        // Words already in flight saw the old settings
        skip_checks     = 5;
    endtask

    task automatic reset_dut();
        sym_word_t zero_slice;
        rst_n   = 1'b0;
        code_in = '0;
        code_q.delete();
        est_q.delete();
        sym_q.delete();
        model_prev      = '0;
        skip_checks     = 0;
        // Reset stages hold zero words and the slicer still slices a zero estimate
        zero_slice.tag  = '0;
        zero_slice.syms = model_slice('0);
        code_q.push_back('0);
        code_q.push_back('0);
        est_q.push_back('0);
        est_q.push_back('0);
        sym_q.push_back('0);
        sym_q.push_back(zero_slice);
        sym_q.push_back(zero_slice);
        for (int c = 0; c < 8; c++) @(posedge clk);
        #2;
        rst_n = 1'b1;
        drive_word('0);
    endtask

    task automatic report_test(input string name);
        $display("Test %s finished with %0d errors", name, error_count - test_start_errors);
    endtask

    task automatic test_reset();
        test_start_errors = error_count;
        reset_dut();
        check_value(code_out, '0, "code_out after reset");
        check_value(est_out, '0, "est_out after reset");
        check_value(sym_out, '0, "sym_out after reset");
        for (int n = 0; n < 4; n++) step(random_word());
        report_test("reset");
    endtask

    task automatic test_code_path();
        code_word_t marker;
        int         cycles;
        test_start_errors = error_count;
        apply_settings(random_weights(), same_shift(6), '0, 10'sd100, 2'd0);
        for (int n = 0; n < 30; n++) step(random_word());
        marker     = random_word();
        marker.tag = 8'hFF;
        step(marker);
        cycles = 0;
        while (code_out.tag !== 8'hFF && cycles < WAIT_LIMIT) begin
            step(random_word());
            cycles++;
        end
        if (code_out.tag !== 8'hFF) begin
            $display("Timeout: marker tag did not reach code_out within %0d cycles", cycles);
            $display("Finished with errors");
            $finish;
        end else begin
            check_value(cycles, 3, "code_out latency in cycles");
            check_value(est_out.tag, 8'hFF, "est_out tag at marker");
            report_test("code_path");
        end
    endtask

    task automatic test_ffe();
        test_start_errors = error_count;
        for (int r = 0; r < 4; r++) begin
            apply_settings(random_weights(), shift_arr_t'(rand_bits(16) & 32'h7777),
                           disable_arr_t'(rand_bits(12)), 10'sd100, 2'd0);
            for (int n = 0; n < 55; n++) step(random_word());
        end
        report_test("ffe");
    endtask

    task automatic test_saturation();
        weight_arr_t big;
        est_vec_t    top;
        est_vec_t    bottom;
        test_start_errors = error_count;
        for (int k = 0; k < `FFE_LENGTH; k++) begin
            for (int i = 0; i < `CHANNEL_WIDTH; i++) big[k][i] = 8'sd127;
        end
        for (int i = 0; i < `CHANNEL_WIDTH; i++) begin
            top[i]    = est_t'(EST_MAX);
            bottom[i] = est_t'(EST_MIN);
        end
        apply_settings(big, '0, '0, 10'sd100, 2'd0);
        for (int n = 0; n < 16; n++) step(strong_word(1'b1));
        check_value(est_out.est, top, "est_out clamped high");
        for (int n = 0; n < 16; n++) step(strong_word(1'b0));
        check_value(est_out.est, bottom, "est_out clamped low");
        report_test("saturation");
    endtask

    task automatic test_slicer();
        logic signed [`OUTPUT_PRECISION-1:0] levels [4];
        test_start_errors = error_count;
        levels = '{10'sd16, 10'sd100, 10'sd250, 10'sd450};
        for (int l = 0; l < 4; l++) begin
            apply_settings(random_weights(), same_shift(6), '0, levels[l], 2'd0);
            for (int n = 0; n < 40; n++) step(random_word());
        end
        report_test("slicer");
    endtask

    task automatic test_align();
        test_start_errors = error_count;
        for (int p = 0; p < 4; p++) begin
            apply_settings(random_weights(), same_shift(6), '0, 10'sd150, p[1:0]);
            for (int n = 0; n < 30; n++) step(random_word());
        end
        report_test("align");
    endtask

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        code_in         = '0;
        weights         = '0;
        ffe_shift       = '0;
        disable_product = '0;
        bit_level       = '0;
        align_pos       = '0;
        lfsr_state      = 16'd69;
        check_count     = 0;
        error_count     = 0;
        skip_checks     = 0;
        test_reset();
        test_code_path();
        test_ffe();
        test_saturation();
        test_slicer();
        test_align();
        check_value(u_bits_estimator_datapath.u_bits_estimator_assert.fail_count, 0,
                    "concurrent assertion failures");
        $display("Summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: build.f
+incdir+include
verilog/constant_pkg.sv
verilog/ffe_pkg.sv
verilog/code_history_buffer.sv
verilog/comb_ffe.sv
verilog/est_bits_pipeline.sv
verilog/pam4_slicer.sv
verilog/bits_estimator_datapath.sv
sim/bits_estimator_assert.sv
sim/tb_bits_estimator.sv

// File: Bender.yml
package:
  name: bits_estimator

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/constant_pkg.sv
      - verilog/ffe_pkg.sv
      - verilog/code_history_buffer.sv
      - verilog/comb_ffe.sv
      - verilog/est_bits_pipeline.sv
      - verilog/pam4_slicer.sv
      - verilog/bits_estimator_datapath.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/bits_estimator_assert.sv
      - sim/tb_bits_estimator.sv
